//--- hw/mem_sched_defines.svh
/*
 * Sizing constants for the memory issue stage.
 * Include wherever queue depth, dispatch width or register widths are needed.
 */
`ifndef MEM_SCHED_DEFINES_SVH
`define MEM_SCHED_DEFINES_SVH

// Issue queue slots
`define IQ_MEM_SIZE 8

// Micro-ops accepted from dispatch per cycle
`define DISPATCH_WIDTH 2

// Physical registers and reorder-buffer tag width
`define PRF_SIZE 32
`define ROB_TAG_W 6

// Load/store address offset
`define IMM_W 12

`endif

//--- hw/mem_uop_pkg.sv
/*
 * Encodings that describe a memory micro-op: its opcode and how each
 * source operand is obtained. Imported by the slot, queue and top.
 */
`default_nettype none

package mem_uop_pkg;

  // Memory opcode
  typedef enum logic {
    MEM_LD = 1'b0,
    MEM_ST = 1'b1
  } mem_op_t;

  // Source select, SRC_ZERO has no register operand and never waits
  typedef enum logic {
    SRC_RF   = 1'b0,
    SRC_ZERO = 1'b1
  } src_sel_t;

endpackage

`default_nettype wire

//--- hw/prf_pkg.sv
/*
 * Physical register file index and reorder-buffer tag types.
 */
`default_nettype none

`include "mem_sched_defines.svh"

package prf_pkg;

  typedef logic [$clog2(`PRF_SIZE)-1:0] prf_index_t;

  typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

endpackage

`default_nettype wire

//--- hw/prf_busy_table.sv
/*
 * One busy bit per physical register. Dispatch of a load marks its
 * destination busy, a writeback pulse clears it, flush clears everything.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module prf_busy_table
  import prf_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,

  input  logic [`DISPATCH_WIDTH-1:0] set_valid,
  input  prf_index_t                 set_index [`DISPATCH_WIDTH],

  input  logic                       wb_valid,
  input  prf_index_t                 wb_index,

  output logic [`PRF_SIZE-1:0]       busy
);

  logic [`PRF_SIZE-1:0] busy_next;

  always_comb begin
    busy_next = busy;
    if (wb_valid) begin
      busy_next[wb_index] = 1'b0;
    end
    // Sets are applied last so they win over a same-edge writeback
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (set_valid[i]) begin
        busy_next[set_index[i]] = 1'b1;
      end
    end
    // x0 is hardwired, never waits
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy <= '0;
    end else begin
      busy <= busy_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/issue_slot_mem.sv
/*
 * One entry of the collapsing memory issue queue. Loads a new micro-op
 * from dispatch or takes over the entry above on compaction, and reports
 * when both of its sources are available.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module issue_slot_mem
  import mem_uop_pkg::*;
  import prf_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,

  // New micro-op from dispatch
  input  logic                 load,
  input  logic                 in_valid,
  input  mem_op_t              in_op,
  input  src_sel_t             in_rs1_src,
  input  prf_index_t           in_rs1,
  input  src_sel_t             in_rs2_src,
  input  prf_index_t           in_rs2,
  input  prf_index_t           in_rd,
  input  logic [`IMM_W-1:0]    in_imm,
  input  rob_tag_t             in_rob_tag,

  // Contents of the slot above, taken on compaction
  input  logic                 shift,
  input  logic                 next_valid,
  input  mem_op_t              next_op,
  input  src_sel_t             next_rs1_src,
  input  prf_index_t           next_rs1,
  input  src_sel_t             next_rs2_src,
  input  prf_index_t           next_rs2,
  input  prf_index_t           next_rd,
  input  logic [`IMM_W-1:0]    next_imm,
  input  rob_tag_t             next_rob_tag,

  output logic                 valid,
  output mem_op_t              op,
  output src_sel_t             rs1_src,
  output prf_index_t           rs1,
  output src_sel_t             rs2_src,
  output prf_index_t           rs2,
  output prf_index_t           rd,
  output logic [`IMM_W-1:0]    imm,
  output rob_tag_t             rob_tag,

  input  logic [`PRF_SIZE-1:0] busy,
  output logic                 ready
);

  logic rs1_ok;
  logic rs2_ok;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= in_valid;
    end else if (shift) begin
      valid <= next_valid;
    end
  end

  // Payload follows valid, load first
  always_ff @(posedge clock) begin
    if (load) begin
      op      <= in_op;
      rs1_src <= in_rs1_src;
      rs1     <= in_rs1;
      rs2_src <= in_rs2_src;
      rs2     <= in_rs2;
      rd      <= in_rd;
      imm     <= in_imm;
      rob_tag <= in_rob_tag;
    end else if (shift) begin
      op      <= next_op;
      rs1_src <= next_rs1_src;
      rs1     <= next_rs1;
      rs2_src <= next_rs2_src;
      rs2     <= next_rs2;
      rd      <= next_rd;
      imm     <= next_imm;
      rob_tag <= next_rob_tag;
    end
  end

  assign rs1_ok = (rs1_src == SRC_ZERO) || !busy[rs1];
  assign rs2_ok = (rs2_src == SRC_ZERO) || !busy[rs2];
  assign ready  = valid && rs1_ok && rs2_ok;

endmodule

`default_nettype wire

//--- hw/issue_select_mem.sv
/*
 * Picks the oldest ready slot of the memory issue queue. Slot 0 is the
 * oldest; a store is only a candidate when it sits in slot 0.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module issue_select_mem #(
  parameter int SEL_W = $clog2(`IQ_MEM_SIZE)
) (
  input  logic [`IQ_MEM_SIZE-1:0] ready,
  input  logic [`IQ_MEM_SIZE-1:0] is_store,
  output logic [SEL_W-1:0]        sel,
  output logic                    sel_valid
);

  logic [`IQ_MEM_SIZE-1:0] candidates;

  // Stores above slot 0 still have older entries ahead of them
  assign candidates = ready & ~{is_store[`IQ_MEM_SIZE-1:1], 1'b0};

  // Priority encoder, lowest index wins
  always_comb begin
    sel       = '0;
    sel_valid = 1'b0;
    for (int i = `IQ_MEM_SIZE - 1; i >= 0; i--) begin
      if (candidates[i]) begin
        sel       = SEL_W'(i);
        sel_valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/issue_queue_mem.sv
/*
 * Eight-entry in-order collapsing issue queue for memory micro-ops.
 * Accepts up to two micro-ops per cycle at the tail, issues the oldest
 * ready entry to the memory pipe and shifts the younger entries down.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module issue_queue_mem
  import mem_uop_pkg::*;
  import prf_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       ex_busy,

  input  logic [`DISPATCH_WIDTH-1:0] disp_valid,
  input  mem_op_t                    disp_op      [`DISPATCH_WIDTH],
  input  src_sel_t                   disp_rs1_src [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rs1     [`DISPATCH_WIDTH],
  input  src_sel_t                   disp_rs2_src [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rs2     [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rd      [`DISPATCH_WIDTH],
  input  logic [`IMM_W-1:0]          disp_imm     [`DISPATCH_WIDTH],
  input  rob_tag_t                   disp_rob_tag [`DISPATCH_WIDTH],
  output logic [`DISPATCH_WIDTH-1:0] disp_accept,

  input  logic [`PRF_SIZE-1:0]       busy,

  output logic                       issue_valid,
  output mem_op_t                    issue_op,
  output prf_index_t                 issue_rs1,
  output prf_index_t                 issue_rs2,
  output prf_index_t                 issue_rd,
  output logic [`IMM_W-1:0]          issue_imm,
  output rob_tag_t                   issue_rob_tag,
  output logic                       iq_full
);

  localparam int IDX_W  = $clog2(`IQ_MEM_SIZE);
  localparam int CNT_W  = IDX_W + 1;
  localparam int LANE_W = $clog2(`DISPATCH_WIDTH);

  // Slot contents, entry IQ_MEM_SIZE is an always-empty slot above the top
  logic [`IQ_MEM_SIZE:0]   s_valid;
  mem_op_t                 s_op      [`IQ_MEM_SIZE+1];
  src_sel_t                s_rs1_src [`IQ_MEM_SIZE+1];
  prf_index_t              s_rs1     [`IQ_MEM_SIZE+1];
  src_sel_t                s_rs2_src [`IQ_MEM_SIZE+1];
  prf_index_t              s_rs2     [`IQ_MEM_SIZE+1];
  prf_index_t              s_rd      [`IQ_MEM_SIZE+1];
  logic [`IMM_W-1:0]       s_imm     [`IQ_MEM_SIZE+1];
  rob_tag_t                s_rob_tag [`IQ_MEM_SIZE+1];

  logic [`IQ_MEM_SIZE-1:0] ready;
  logic [`IQ_MEM_SIZE-1:0] is_store;
  logic [`IQ_MEM_SIZE-1:0] load;
  logic [`IQ_MEM_SIZE-1:0] shift;
  logic [LANE_W-1:0]       lane_sel  [`IQ_MEM_SIZE];

  logic [IDX_W-1:0]        sel;
  logic                    sel_valid;
  logic                    issue_fire;

  logic [CNT_W-1:0]        occupancy;
  logic [CNT_W-1:0]        in_count;
  logic [CNT_W-1:0]        tail;
  logic [CNT_W-1:0]        pos;

  assign s_valid[`IQ_MEM_SIZE]   = 1'b0;
  assign s_op[`IQ_MEM_SIZE]      = MEM_LD;
  assign s_rs1_src[`IQ_MEM_SIZE] = SRC_ZERO;
  assign s_rs1[`IQ_MEM_SIZE]     = '0;
  assign s_rs2_src[`IQ_MEM_SIZE] = SRC_ZERO;
  assign s_rs2[`IQ_MEM_SIZE]     = '0;
  assign s_rd[`IQ_MEM_SIZE]      = '0;
  assign s_imm[`IQ_MEM_SIZE]     = '0;
  assign s_rob_tag[`IQ_MEM_SIZE] = '0;

  // Full means fewer than DISPATCH_WIDTH free slots, issue not counted
  assign iq_full     = (CNT_W'(`IQ_MEM_SIZE) - occupancy) < CNT_W'(`DISPATCH_WIDTH);
  assign disp_accept = disp_valid & {`DISPATCH_WIDTH{~iq_full}};

  assign issue_fire = sel_valid && !ex_busy;
  assign tail       = occupancy - CNT_W'(issue_fire);

  // Pack accepted lanes in order from the tail
  always_comb begin
    load     = '0;
    in_count = '0;
    pos      = tail;
    for (int k = 0; k < `IQ_MEM_SIZE; k++) begin
      lane_sel[k] = '0;
    end
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (disp_accept[i]) begin
        load[pos[IDX_W-1:0]]     = 1'b1;
        lane_sel[pos[IDX_W-1:0]] = LANE_W'(i);
        pos                      = pos + 1'b1;
        in_count                 = in_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      occupancy <= '0;
    end else begin
      occupancy <= tail + in_count;
    end
  end

  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_slot
    assign shift[k]    = issue_fire && (IDX_W'(k) >= sel);
    assign is_store[k] = (s_op[k] == MEM_ST);

    issue_slot_mem u_slot (
      .clock        (clock),
      .reset        (reset),
      .flush        (flush),
      .load         (load[k]),
      .in_valid     (disp_accept[lane_sel[k]]),
      .in_op        (disp_op[lane_sel[k]]),
      .in_rs1_src   (disp_rs1_src[lane_sel[k]]),
      .in_rs1       (disp_rs1[lane_sel[k]]),
      .in_rs2_src   (disp_rs2_src[lane_sel[k]]),
      .in_rs2       (disp_rs2[lane_sel[k]]),
      .in_rd        (disp_rd[lane_sel[k]]),
      .in_imm       (disp_imm[lane_sel[k]]),
      .in_rob_tag   (disp_rob_tag[lane_sel[k]]),
      .shift        (shift[k]),
      .next_valid   (s_valid[k+1]),
      .next_op      (s_op[k+1]),
      .next_rs1_src (s_rs1_src[k+1]),
      .next_rs1     (s_rs1[k+1]),
      .next_rs2_src (s_rs2_src[k+1]),
      .next_rs2     (s_rs2[k+1]),
      .next_rd      (s_rd[k+1]),
      .next_imm     (s_imm[k+1]),
      .next_rob_tag (s_rob_tag[k+1]),
      .valid        (s_valid[k]),
      .op           (s_op[k]),
      .rs1_src      (s_rs1_src[k]),
      .rs1          (s_rs1[k]),
      .rs2_src      (s_rs2_src[k]),
      .rs2          (s_rs2[k]),
      .rd           (s_rd[k]),
      .imm          (s_imm[k]),
      .rob_tag      (s_rob_tag[k]),
      .busy         (busy),
      .ready        (ready[k])
    );
  end

  issue_select_mem u_select (
    .ready     (ready),
    .is_store  (is_store),
    .sel       (sel),
    .sel_valid (sel_valid)
  );

  assign issue_valid   = sel_valid;
  assign issue_op      = s_op[sel];
  assign issue_rs1     = s_rs1[sel];
  assign issue_rs2     = s_rs2[sel];
  assign issue_rd      = s_rd[sel];
  assign issue_imm     = s_imm[sel];
  assign issue_rob_tag = s_rob_tag[sel];

endmodule

`default_nettype wire

//--- hw/mem_issue_top.sv
/*
 * Memory issue stage: busy table plus collapsing issue queue.
 * Takes two dispatch lanes and writeback pulses, feeds one memory pipe.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module mem_issue_top
  import mem_uop_pkg::*;
  import prf_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,

  input  logic [`DISPATCH_WIDTH-1:0] disp_valid,
  input  mem_op_t                    disp_op      [`DISPATCH_WIDTH],
  input  src_sel_t                   disp_rs1_src [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rs1     [`DISPATCH_WIDTH],
  input  src_sel_t                   disp_rs2_src [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rs2     [`DISPATCH_WIDTH],
  input  prf_index_t                 disp_rd      [`DISPATCH_WIDTH],
  input  logic [`IMM_W-1:0]          disp_imm     [`DISPATCH_WIDTH],
  input  rob_tag_t                   disp_rob_tag [`DISPATCH_WIDTH],

  input  logic                       wb_valid,
  input  prf_index_t                 wb_index,

  input  logic                       ex_busy,

  output logic                       issue_valid,
  output mem_op_t                    issue_op,
  output prf_index_t                 issue_rs1,
  output prf_index_t                 issue_rs2,
  output prf_index_t                 issue_rd,
  output logic [`IMM_W-1:0]          issue_imm,
  output rob_tag_t                   issue_rob_tag,
  output logic                       iq_full
);

  logic [`PRF_SIZE-1:0]       busy;
  logic [`DISPATCH_WIDTH-1:0] disp_accept;
  logic [`DISPATCH_WIDTH-1:0] set_valid;

  // Only accepted loads produce a result register
  for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_set
    assign set_valid[i] = disp_accept[i] && (disp_op[i] == MEM_LD);
  end

  prf_busy_table u_busy_table (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .set_valid (set_valid),
    .set_index (disp_rd),
    .wb_valid  (wb_valid),
    .wb_index  (wb_index),
    .busy      (busy)
  );

  issue_queue_mem u_queue (
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .ex_busy       (ex_busy),
    .disp_valid    (disp_valid),
    .disp_op       (disp_op),
    .disp_rs1_src  (disp_rs1_src),
    .disp_rs1      (disp_rs1),
    .disp_rs2_src  (disp_rs2_src),
    .disp_rs2      (disp_rs2),
    .disp_rd       (disp_rd),
    .disp_imm      (disp_imm),
    .disp_rob_tag  (disp_rob_tag),
    .disp_accept   (disp_accept),
    .busy          (busy),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_rob_tag (issue_rob_tag),
    .iq_full       (iq_full)
  );

endmodule

`default_nettype wire

//--- sim/mem_issue_props.sv
/*
 * Concurrent checks on the memory issue queue, bound into every
 * issue_queue_mem instance.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module mem_issue_props
  import mem_uop_pkg::*;
(
  input logic                              clock,
  input logic                              reset,
  input logic                              flush,
  input logic                              ex_busy,
  input logic [`DISPATCH_WIDTH-1:0]        disp_accept,
  input logic                              issue_fire,
  input mem_op_t                           issue_op,
  input logic [$clog2(`IQ_MEM_SIZE)-1:0]   sel,
  input logic [$clog2(`IQ_MEM_SIZE):0]     occupancy,
  input logic                              iq_full
);

  // Queue comes out of reset empty
  a_full_after_reset: assert property (@(posedge clock) reset |=> !iq_full)
    else $error("iq_full high right after reset");

  // Under back-pressure only accepted dispatches change the count
  a_hold_on_busy: assert property (@(posedge clock) disable iff (reset)
    (ex_busy && !flush) |=>
      occupancy == $past(occupancy) + $countones($past(disp_accept)))
    else $error("entry issued while ex_busy was high");

  a_store_slot0: assert property (@(posedge clock) disable iff (reset)
    (issue_fire && issue_op == MEM_ST) |-> (sel == '0))
    else $error("store issued from slot %0d", sel);

  a_occupancy: assert property (@(posedge clock) disable iff (reset)
    occupancy <= `IQ_MEM_SIZE)
    else $error("occupancy %0d above queue size", occupancy);

endmodule

bind issue_queue_mem mem_issue_props u_props (
  .clock       (clock),
  .reset       (reset),
  .flush       (flush),
  .ex_busy     (ex_busy),
  .disp_accept (disp_accept),
  .issue_fire  (issue_fire),
  .issue_op    (issue_op),
  .sel         (sel),
  .occupancy   (occupancy),
  .iq_full     (iq_full)
);

`default_nettype wire

//--- sim/mem_issue_tb.sv
/*
 * Testbench for the memory issue stage. Drives seeded random dispatch, wakeup,
 * back-pressure and flush traffic and compares the DUT with a cycle model.
 */
`default_nettype none
`timescale 1ns/1ps

`include "mem_sched_defines.svh"

module mem_issue_tb
  import mem_uop_pkg::*;
  import prf_pkg::*;
();

  localparam int PERIOD      = 100;
  localparam int NQ          = `IQ_MEM_SIZE;
  localparam int TEST_CYCLES = 16 + 40 + 80 + 80 + 12 + 12 + 8 + 1 + 10 + 2000 + 1;

  logic                       clock;
  logic                       reset;
  logic                       flush;
  logic [`DISPATCH_WIDTH-1:0] disp_valid;
  mem_op_t                    disp_op      [`DISPATCH_WIDTH];
  src_sel_t                   disp_rs1_src [`DISPATCH_WIDTH];
  prf_index_t                 disp_rs1     [`DISPATCH_WIDTH];
  src_sel_t                   disp_rs2_src [`DISPATCH_WIDTH];
  prf_index_t                 disp_rs2     [`DISPATCH_WIDTH];
  prf_index_t                 disp_rd      [`DISPATCH_WIDTH];
  logic [`IMM_W-1:0]          disp_imm     [`DISPATCH_WIDTH];
  rob_tag_t                   disp_rob_tag [`DISPATCH_WIDTH];
  logic                       wb_valid;
  prf_index_t                 wb_index;
  logic                       ex_busy;
  logic                       issue_valid;
  mem_op_t                    issue_op;
  prf_index_t                 issue_rs1;
  prf_index_t                 issue_rs2;
  prf_index_t                 issue_rd;
  logic [`IMM_W-1:0]          issue_imm;
  rob_tag_t                   issue_rob_tag;
  logic                       iq_full;

  // Model queue, entry 0 is the oldest
  mem_op_t              m_op      [NQ];
  src_sel_t             m_rs1_src [NQ];
  prf_index_t           m_rs1     [NQ];
  src_sel_t             m_rs2_src [NQ];
  prf_index_t           m_rs2     [NQ];
  prf_index_t           m_rd      [NQ];
  logic [`IMM_W-1:0]    m_imm     [NQ];
  rob_tag_t             m_tag     [NQ];
  int                   m_cnt;
  logic [`PRF_SIZE-1:0] m_busy;

  int seed;
  int errors;
  int next_tag;
  // Traffic mix in percent
  int p_disp;
  int p_rf;
  int p_st;
  int p_wb;
  int p_exb;
  int p_flush;

  mem_issue_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  initial begin
    #((TEST_CYCLES + 100) * PERIOD);
    $display("Timeout, the run did not finish within its cycle budget");
    $display("Test FAILED");
    $fatal(1);
  end

  function automatic int roll(int n);
    return int'($unsigned($random(seed)) % 32'(n));
  endfunction

  function automatic logic entry_ready(int j);
    return (m_rs1_src[j] == SRC_ZERO || !m_busy[m_rs1[j]]) &&
           (m_rs2_src[j] == SRC_ZERO || !m_busy[m_rs2[j]]);
  endfunction

  // Oldest ready entry, stores only when they are the oldest
  function automatic int model_select();
    for (int j = 0; j < m_cnt; j++) begin
      if (entry_ready(j) && (m_op[j] == MEM_LD || j == 0)) begin
        return j;
      end
    end
    return -1;
  endfunction

  task automatic report_failure();
    errors = errors + 1;
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_op(string name, mem_op_t got, mem_op_t exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_index(string name, prf_index_t got, prf_index_t exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_imm(string name, logic [`IMM_W-1:0] got, logic [`IMM_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_busy(string name, logic [`PRF_SIZE-1:0] got,
                            logic [`PRF_SIZE-1:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic set_mix(int disp, int rf, int st, int wb, int exb, int fl);
    p_disp  = disp;
    p_rf    = rf;
    p_st    = st;
    p_wb    = wb;
    p_exb   = exb;
    p_flush = fl;
  endtask

  task automatic copy_entry(int dst, int src);
    m_op[dst]      = m_op[src];
    m_rs1_src[dst] = m_rs1_src[src];
    m_rs1[dst]     = m_rs1[src];
    m_rs2_src[dst] = m_rs2_src[src];
    m_rs2[dst]     = m_rs2[src];
    m_rd[dst]      = m_rd[src];
    m_imm[dst]     = m_imm[src];
    m_tag[dst]     = m_tag[src];
  endtask

  task automatic drive_inputs(logic full);
    prf_index_t cand [$];
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      disp_valid[i]   = !full && (roll(100) < p_disp);
      disp_op[i]      = (roll(100) < p_st) ? MEM_ST : MEM_LD;
      disp_rs1_src[i] = (roll(100) < p_rf) ? SRC_RF : SRC_ZERO;
      disp_rs1[i]     = prf_index_t'(roll(`PRF_SIZE));
      disp_rs2_src[i] = (roll(100) < p_rf) ? SRC_RF : SRC_ZERO;
      disp_rs2[i]     = prf_index_t'(roll(`PRF_SIZE));
      // Stores write no register
      disp_rd[i]      = (disp_op[i] == MEM_LD) ? prf_index_t'(roll(`PRF_SIZE)) : '0;
      disp_imm[i]     = `IMM_W'(roll(1 << `IMM_W));
      disp_rob_tag[i] = rob_tag_t'(next_tag);
      next_tag        = next_tag + 1;
    end
    for (int r = 1; r < `PRF_SIZE; r++) begin
      if (m_busy[r]) begin
        cand.push_back(prf_index_t'(r));
      end
    end
    wb_valid = (cand.size() > 0) && (roll(100) < p_wb);
    if (wb_valid) begin
      wb_index = cand[roll(cand.size())];
    end else begin
      wb_index = prf_index_t'(roll(`PRF_SIZE));
    end
    ex_busy = roll(100) < p_exb;
    flush   = roll(100) < p_flush;
  endtask

  task automatic update_model(int sel);
    if (flush) begin
      m_cnt  = 0;
      m_busy = '0;
    end else begin
      if (sel >= 0 && !ex_busy) begin
        for (int j = sel; j < m_cnt - 1; j++) begin
          copy_entry(j, j + 1);
        end
        m_cnt = m_cnt - 1;
      end
      if (wb_valid) begin
        m_busy[wb_index] = 1'b0;
      end
      // Dispatch set is applied after the wakeup clear
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (disp_valid[i]) begin
          m_op[m_cnt]      = disp_op[i];
          m_rs1_src[m_cnt] = disp_rs1_src[i];
          m_rs1[m_cnt]     = disp_rs1[i];
          m_rs2_src[m_cnt] = disp_rs2_src[i];
          m_rs2[m_cnt]     = disp_rs2[i];
          m_rd[m_cnt]      = disp_rd[i];
          m_imm[m_cnt]     = disp_imm[i];
          m_tag[m_cnt]     = disp_rob_tag[i];
          if (disp_op[i] == MEM_LD) begin
            m_busy[disp_rd[i]] = 1'b1;
          end
          m_cnt = m_cnt + 1;
        end
      end
      m_busy[0] = 1'b0;
    end
  endtask

  // Check outputs settled since the last rising edge, then drive the next cycle
  task automatic step();
    int   sel;
    logic full;
    @(negedge clock);
    sel  = model_select();
    full = (NQ - m_cnt) < `DISPATCH_WIDTH;
    check_flag("iq_full", iq_full, full);
    check_flag("issue_valid", issue_valid, sel >= 0);
    if (sel >= 0) begin
      check_op("issue_op", issue_op, m_op[sel]);
      check_index("issue_rs1", issue_rs1, m_rs1[sel]);
      check_index("issue_rs2", issue_rs2, m_rs2[sel]);
      check_index("issue_rd", issue_rd, m_rd[sel]);
      check_imm("issue_imm", issue_imm, m_imm[sel]);
      check_tag("issue_rob_tag", issue_rob_tag, m_tag[sel]);
    end
    check_busy("busy", uut.busy, m_busy);
    drive_inputs(full);
    update_model(sel);
  endtask

  task automatic run(int n);
    repeat (n) begin
      step();
    end
  endtask

  initial begin
    seed       = 32'hecb0c82b;
    errors     = 0;
    next_tag   = 0;
    m_cnt      = 0;
    m_busy     = '0;
    reset      = 1'b1;
    flush      = 1'b0;
    disp_valid = '0;
    wb_valid   = 1'b0;
    wb_index   = '0;
    ex_busy    = 1'b0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      disp_op[i]      = MEM_LD;
      disp_rs1_src[i] = SRC_ZERO;
      disp_rs1[i]     = '0;
      disp_rs2_src[i] = SRC_ZERO;
      disp_rs2[i]     = '0;
      disp_rd[i]      = '0;
      disp_imm[i]     = '0;
      disp_rob_tag[i] = '0;
    end
    set_mix(0, 0, 0, 0, 0, 0);
    repeat (16) @(negedge clock);
    reset = 1'b0;

    // Loads with no register sources, in order
    set_mix(60, 0, 0, 0, 0, 0);
    run(40);
    // Busy sources and wakeups
    set_mix(50, 70, 0, 30, 0, 0);
    run(80);
    // Stores mixed in among loads
    set_mix(50, 40, 40, 30, 0, 0);
    run(80);
    // Fill under back-pressure, then drain
    set_mix(100, 30, 20, 0, 100, 0);
    run(12);
    set_mix(0, 30, 20, 60, 0, 0);
    run(12);
    // Flush with busy registers outstanding, dispatch and wakeup ignored
    set_mix(80, 80, 10, 0, 50, 0);
    run(8);
    set_mix(80, 80, 10, 50, 0, 100);
    run(1);
    set_mix(80, 100, 0, 0, 0, 0);
    run(10);
    // Long random mix
    set_mix(50, 50, 25, 35, 30, 1);
    run(2000);
    set_mix(0, 0, 0, 0, 0, 0);
    run(1);

    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hw
hw/mem_uop_pkg.sv
hw/prf_pkg.sv
hw/prf_busy_table.sv
hw/issue_slot_mem.sv
hw/issue_select_mem.sv
hw/issue_queue_mem.sv
hw/mem_issue_top.sv
sim/mem_issue_props.sv
sim/mem_issue_tb.sv

//--- Makefile
TOP = mem_issue_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
